// File: common/uart_pkg.sv
package uart_pkg;

    // one serial character, also the queue word
    typedef logic [7:0] byte_t;

    // wishbone side
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_addr_t;

    // register offsets, bits 3:2 pick the register
    localparam wb_addr_t ADDR_DATA   = 4'h0;
    localparam wb_addr_t ADDR_STATUS = 4'h4;

    // STATUS bit positions
    localparam int ST_TX_EMPTY       = 0;
    localparam int ST_TX_ALMOST_FULL = 1;
    localparam int ST_TX_FULL        = 2;
    localparam int ST_RX_EMPTY       = 3;
    localparam int ST_RX_ALMOST_FULL = 4;
    localparam int ST_RX_OVERRUN     = 5;
    localparam int ST_FRAME_ERR      = 6;
    // rx full sits above the error bits
    localparam int ST_RX_FULL        = 7;

endpackage

// File: common/fifo_if.sv
`timescale 1ns/1ps

interface fifo_if #(
    parameter int FIFO_ADDR_WIDTH = 5
);
    import uart_pkg::*;

    // words the queue holds when full
    localparam int CAPACITY = (1 << FIFO_ADDR_WIDTH) - 1;

    // write port
    byte_t write_data;
    logic  write_enable;

    // read port
    logic  read_enable;
    byte_t read_data;
    logic  read_valid;

    // flags
    logic  empty;
    logic  almost_full;
    logic  full;

    modport producer (
        output write_data, write_enable,
        input  empty, almost_full, full
    );

    modport consumer (
        output read_enable,
        input  read_data, read_valid, empty, almost_full, full
    );

    modport queue (
        input  write_data, write_enable, read_enable,
        output read_data, read_valid, empty, almost_full, full
    );

endinterface

// File: hdl/fifo.sv
`timescale 1ns/1ps

module fifo #(
    parameter int FIFO_ADDR_WIDTH    = 5,
    parameter int ALMOST_FULL_MARGIN = 2
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    fifo_if.queue q
);
    import uart_pkg::*;

    typedef logic [FIFO_ADDR_WIDTH-1:0] addr_t;

    localparam addr_t CAPACITY          = addr_t'((1 << FIFO_ADDR_WIDTH) - 1);
    localparam addr_t ALMOST_FULL_COUNT = CAPACITY - addr_t'(ALMOST_FULL_MARGIN);

    // interface and queue must agree on depth
    if (q.CAPACITY != int'(CAPACITY)) begin : g_depth_check
        $error("fifo: depth differs from the attached fifo_if");
    end

    byte_t mem_r [CAPACITY:0];

    addr_t wr_ptr_r;
    addr_t rd_ptr_r;
    addr_t wr_ptr_next;
    addr_t rd_ptr_next;
    addr_t count_next;

    logic  wr_fire;
    logic  rd_fire;
    byte_t read_data_r;
    logic  read_valid_r;
    logic  empty_r;
    logic  almost_full_r;
    logic  full_r;

    // full queue drops writes, empty queue ignores reads
    assign wr_fire = q.write_enable && !full_r;
    assign rd_fire = q.read_enable && !empty_r;

    always_comb begin
        wr_ptr_next = wr_fire ? wr_ptr_r + 1'b1 : wr_ptr_r;
        rd_ptr_next = rd_fire ? rd_ptr_r + 1'b1 : rd_ptr_r;
    end

    // wraps modulo the pointer width
    assign count_next = wr_ptr_next - rd_ptr_next;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_r      <= '0;
            rd_ptr_r      <= '0;
            read_data_r   <= '0;
            read_valid_r  <= 1'b0;
            empty_r       <= 1'b1;
            almost_full_r <= 1'b0;
            full_r        <= 1'b0;
        end else begin
            wr_ptr_r      <= wr_ptr_next;
            rd_ptr_r      <= rd_ptr_next;
            read_valid_r  <= rd_fire;
            empty_r       <= (count_next == '0);
            almost_full_r <= (count_next >= ALMOST_FULL_COUNT);
            full_r        <= (count_next == CAPACITY);
            if (rd_fire) begin
                read_data_r <= mem_r[rd_ptr_r];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem_r[wr_ptr_r] <= q.write_data;
        end
    end

    assign q.read_data   = read_data_r;
    assign q.read_valid  = read_valid_r;
    assign q.empty       = empty_r;
    assign q.almost_full = almost_full_r;
    assign q.full        = full_r;

    // producers are expected to look at the flags first
    assert property (@(posedge clk_i) disable iff (!rst_n_i) q.write_enable |-> !q.full)
        else $error("fifo: write_enable while full");
    assert property (@(posedge clk_i) disable iff (!rst_n_i) q.read_enable |-> !q.empty)
        else $error("fifo: read_enable while empty");

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    fifo_if.consumer q,
    output logic     tx_o
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef enum logic [2:0] {TX_IDLE, TX_FETCH, TX_START, TX_DATA, TX_STOP} tx_state_t;

    localparam cnt_t CNT_LAST = cnt_t'(CLKS_PER_BIT - 1);

    tx_state_t  state_r;
    cnt_t       cnt_r;
    logic [2:0] bit_idx_r;
    byte_t      shift_r;
    logic       bit_done;

    assign bit_done = (cnt_r == CNT_LAST);

    // one pop per frame, only from idle
    assign q.read_enable = (state_r == TX_IDLE) && !q.empty;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_r   <= TX_IDLE;
            cnt_r     <= '0;
            bit_idx_r <= '0;
            shift_r   <= '0;
            tx_o      <= 1'b1;
        end else begin
            cnt_r <= (state_r == TX_IDLE || state_r == TX_FETCH || bit_done) ? '0 : cnt_r + 1'b1;
            case (state_r)
                TX_IDLE: begin
                    tx_o <= 1'b1;
                    if (!q.empty) begin
                        state_r <= TX_FETCH;
                    end
                end
                TX_FETCH: begin
                    if (q.read_valid) begin
                        shift_r   <= q.read_data;
                        bit_idx_r <= '0;
                        tx_o      <= 1'b0;
                        state_r   <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        tx_o    <= shift_r[0];
                        state_r <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx_r <= bit_idx_r + 1'b1;
                        if (bit_idx_r == 3'd7) begin
                            tx_o    <= 1'b1;
                            state_r <= TX_STOP;
                        end else begin
                            // lsb first
                            shift_r <= {1'b0, shift_r[7:1]};
                            tx_o    <= shift_r[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state_r <= TX_IDLE;
                    end
                end
                default: state_r <= TX_IDLE;
            endcase
        end
    end

    // line idles high between frames
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (state_r == TX_IDLE) |-> tx_o)
        else $error("uart_tx: line low while idle");

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     rx_i,
    fifo_if.producer q,
    output logic     overrun_o,
    output logic     frame_err_o
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    localparam cnt_t CNT_LAST = cnt_t'(CLKS_PER_BIT - 1);
    localparam cnt_t CNT_HALF = cnt_t'(CLKS_PER_BIT / 2 - 1);

    rx_state_t  state_r;
    cnt_t       cnt_r;
    logic [2:0] bit_idx_r;
    byte_t      shift_r;
    logic       rx_meta_r;
    logic       rx_sync_r;
    logic       rx_prev_r;
    logic       fall_edge;
    logic       push_r;

    // two-flop synchronizer, third flop for edge detect
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta_r <= 1'b1;
            rx_sync_r <= 1'b1;
            rx_prev_r <= 1'b1;
        end else begin
            rx_meta_r <= rx_i;
            rx_sync_r <= rx_meta_r;
            rx_prev_r <= rx_sync_r;
        end
    end

    // a falling edge, so a low stop bit cannot retrigger
    assign fall_edge = rx_prev_r && !rx_sync_r;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_r     <= RX_IDLE;
            cnt_r       <= '0;
            bit_idx_r   <= '0;
            shift_r     <= '0;
            push_r      <= 1'b0;
            overrun_o   <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            push_r      <= 1'b0;
            overrun_o   <= 1'b0;
            frame_err_o <= 1'b0;
            cnt_r       <= cnt_r + 1'b1;
            case (state_r)
                RX_IDLE: begin
                    cnt_r <= '0;
                    if (fall_edge) begin
                        state_r <= RX_START;
                    end
                end
                RX_START: begin
                    // recheck at mid start bit, glitches go back to idle
                    if (cnt_r == CNT_HALF) begin
                        cnt_r     <= '0;
                        bit_idx_r <= '0;
                        state_r   <= rx_sync_r ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (cnt_r == CNT_LAST) begin
                        cnt_r     <= '0;
                        shift_r   <= {rx_sync_r, shift_r[7:1]};
                        bit_idx_r <= bit_idx_r + 1'b1;
                        if (bit_idx_r == 3'd7) begin
                            state_r <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cnt_r == CNT_LAST) begin
                        state_r <= RX_IDLE;
                        if (!rx_sync_r) begin
                            frame_err_o <= 1'b1;
                        end else if (q.full) begin
                            overrun_o <= 1'b1;
                        end else begin
                            push_r <= 1'b1;
                        end
                    end
                end
                default: state_r <= RX_IDLE;
            endcase
        end
    end

    // only rx pushes, so full cannot rise before this lands
    assign q.write_enable = push_r;
    assign q.write_data   = shift_r;

endmodule

// File: hdl/wb_uart_regs.sv
`timescale 1ns/1ps

module wb_uart_regs (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  uart_pkg::wb_addr_t wb_adr_i,
    input  uart_pkg::wb_data_t wb_dat_i,
    input  logic [3:0]         wb_sel_i,
    output uart_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack_o,
    fifo_if.producer           tx_q,
    fifo_if.consumer           rx_q,
    input  logic               overrun_i,
    input  logic               frame_err_i
);
    import uart_pkg::*;

    typedef enum logic [1:0] {BUS_IDLE, BUS_POP, BUS_ACK} bus_state_t;

    bus_state_t state_r;
    bus_state_t state_next;
    logic       bus_cycle;
    logic       bus_req;
    logic       sel_data;
    logic       sel_status;
    logic       clear_sticky;
    logic       overrun_r;
    logic       frame_err_r;
    wb_data_t   status_word;
    wb_data_t   dat_next;

    assign bus_cycle  = wb_cyc_i && wb_stb_i;
    assign bus_req    = bus_cycle && (state_r == BUS_IDLE);
    assign sel_data   = (wb_adr_i[3:2] == ADDR_DATA[3:2]);
    assign sel_status = (wb_adr_i[3:2] == ADDR_STATUS[3:2]);

    always_comb begin
        status_word                    = '0;
        status_word[ST_TX_EMPTY]       = tx_q.empty;
        status_word[ST_TX_ALMOST_FULL] = tx_q.almost_full;
        status_word[ST_TX_FULL]        = tx_q.full;
        status_word[ST_RX_EMPTY]       = rx_q.empty;
        status_word[ST_RX_ALMOST_FULL] = rx_q.almost_full;
        status_word[ST_RX_OVERRUN]     = overrun_r;
        status_word[ST_FRAME_ERR]      = frame_err_r;
        status_word[ST_RX_FULL]        = rx_q.full;
    end

    // byte lane 0 carries the character, full queue drops it
    assign tx_q.write_data   = wb_dat_i[7:0];
    assign tx_q.write_enable = bus_req && wb_we_i && sel_data && wb_sel_i[0] && !tx_q.full;

    assign rx_q.read_enable = bus_req && !wb_we_i && sel_data && !rx_q.empty;

    // status word is latched on this edge with the old sticky bits
    assign clear_sticky = bus_req && !wb_we_i && sel_status;

    always_comb begin
        state_next = state_r;
        dat_next   = wb_dat_o;
        case (state_r)
            BUS_IDLE: begin
                if (bus_cycle) begin
                    state_next = (!wb_we_i && sel_data) ? BUS_POP : BUS_ACK;
                    if (!wb_we_i) begin
                        dat_next = sel_status ? status_word : '0;
                    end
                end
            end
            BUS_POP: begin
                // registered fifo data shows up here
                dat_next   = rx_q.read_valid ? wb_data_t'(rx_q.read_data) : '0;
                state_next = BUS_ACK;
            end
            BUS_ACK: state_next = BUS_IDLE;
            default: state_next = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_r     <= BUS_IDLE;
            wb_ack_o    <= 1'b0;
            wb_dat_o    <= '0;
            overrun_r   <= 1'b0;
            frame_err_r <= 1'b0;
        end else begin
            state_r     <= state_next;
            wb_ack_o    <= (state_next == BUS_ACK);
            wb_dat_o    <= dat_next;
            // a new event on the clearing edge still sticks
            overrun_r   <= (overrun_r && !clear_sticky) || overrun_i;
            frame_err_r <= (frame_err_r && !clear_sticky) || frame_err_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_ack_o |=> !wb_ack_o)
        else $error("wb_uart_regs: ack held for two cycles");

endmodule

// File: hdl/wb_uart.sv
`timescale 1ns/1ps

module wb_uart #(
    parameter int CLKS_PER_BIT       = 16,
    parameter int FIFO_ADDR_WIDTH    = 5,
    parameter int ALMOST_FULL_MARGIN = 2
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  uart_pkg::wb_addr_t wb_adr_i,
    input  uart_pkg::wb_data_t wb_dat_i,
    input  logic [3:0]         wb_sel_i,
    output uart_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack_o,
    output logic               tx_o,
    input  logic               rx_i
);
    logic overrun;
    logic frame_err;

    fifo_if #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) tx_q ();
    fifo_if #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) rx_q ();

    wb_uart_regs u_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .tx_q        (tx_q.producer),
        .rx_q        (rx_q.consumer),
        .overrun_i   (overrun),
        .frame_err_i (frame_err)
    );

    fifo #(
        .FIFO_ADDR_WIDTH    (FIFO_ADDR_WIDTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) tx_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .q       (tx_q.queue)
    );

    fifo #(
        .FIFO_ADDR_WIDTH    (FIFO_ADDR_WIDTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) rx_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .q       (rx_q.queue)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .q       (tx_q.consumer),
        .tx_o    (tx_o)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rx_i        (rx_i),
        .q           (rx_q.producer),
        .overrun_o   (overrun),
        .frame_err_o (frame_err)
    );

endmodule

// File: sim/tb_wb_uart.sv
`timescale 1ns/1ps

module tb_wb_uart;
    import uart_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int QUEUE_DEPTH  = 31;
    localparam int ACK_LIMIT    = 20;
    localparam int POLL_LIMIT   = 2000;
    localparam int START_LIMIT  = 60 * CLKS_PER_BIT;

    logic       clk_i;
    logic       rst_n_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    wb_addr_t   wb_adr_i;
    wb_data_t   wb_dat_i;
    logic [3:0] wb_sel_i;
    wb_data_t   wb_dat_o;
    logic       wb_ack_o;
    logic       tx_o;
    logic       rx_i;

    logic [31:0] lfsr_state;
    // expected bytes per direction
    byte_t       tx_model[$];
    byte_t       rx_model[$];

    wb_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) DUT (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .tx_o     (tx_o),
        .rx_i     (rx_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // galois form, shifts right
    function automatic logic lfsr_next_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'hd000_0001;
        end
        return out_bit;
    endfunction

    function automatic byte_t random_byte();
        byte_t value;
        int    i;
        for (i = 0; i < 8; i++) begin
            value[i] = lfsr_next_bit();
        end
        return value;
    endfunction

    function automatic wb_data_t expected_status(
        input logic tx_empty,
        input logic tx_almost_full,
        input logic tx_full,
        input logic rx_empty,
        input logic rx_almost_full,
        input logic rx_full,
        input logic overrun,
        input logic frame_err
    );
        wb_data_t word;
        word                    = '0;
        word[ST_TX_EMPTY]       = tx_empty;
        word[ST_TX_ALMOST_FULL] = tx_almost_full;
        word[ST_TX_FULL]        = tx_full;
        word[ST_RX_EMPTY]       = rx_empty;
        word[ST_RX_ALMOST_FULL] = rx_almost_full;
        word[ST_RX_FULL]        = rx_full;
        word[ST_RX_OVERRUN]     = overrun;
        word[ST_FRAME_ERR]      = frame_err;
        return word;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("ERROR at time %0t: timed out waiting for %s", $time, what);
        $display("Regression failed");
        $fatal(1, "timeout");
    endtask

    // one classic cycle, returns when ack is seen
    task automatic bus_cycle(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = addr;
        wb_dat_i = wdata;
        wb_sel_i = 4'hf;
        waited   = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!wb_ack_o && waited < ACK_LIMIT);
        if (!wb_ack_o) begin
            abort_on_timeout("wb_ack_o");
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    // start, eight data bits lsb first, stop, then one idle bit
    task automatic send_frame(input byte_t value, input logic bad_stop);
        logic [9:0] frame;
        int         i;
        frame = {!bad_stop, value, 1'b0};
        @(negedge clk_i);
        for (i = 0; i < 10; i++) begin
            rx_i = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk_i);
        end
        rx_i = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk_i);
    endtask

    task automatic recv_frame(output byte_t value);
        int waited;
        int i;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (tx_o !== 1'b0 && waited < START_LIMIT);
        if (tx_o !== 1'b0) begin
            abort_on_timeout("a start bit on tx_o");
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
        check("tx_o start bit", tx_o, 32'd0);
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_i);
            value[i] = tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk_i);
        check("tx_o stop bit", tx_o, 32'd1);
    endtask

    task automatic expect_tx_bytes(input int count);
        byte_t got;
        int    i;
        for (i = 0; i < count; i++) begin
            recv_frame(got);
            check("tx_model size", (tx_model.size() > 0) ? 32'd1 : 32'd0, 32'd1);
            check("tx_o byte", got, tx_model.pop_front());
        end
    endtask

    task automatic write_random_bytes(input int count);
        byte_t value;
        int    i;
        for (i = 0; i < count; i++) begin
            value = random_byte();
            tx_model.push_back(value);
            wb_write(ADDR_DATA, wb_data_t'(value));
        end
    endtask

    // writes only after STATUS shows room in the tx queue
    task automatic write_when_not_full(input int count, output int full_seen);
        wb_data_t status;
        byte_t    value;
        int       sent;
        int       polls;
        sent      = 0;
        polls     = 0;
        full_seen = 0;
        while (sent < count) begin
            wb_read(ADDR_STATUS, status);
            polls++;
            if (polls > POLL_LIMIT) begin
                abort_on_timeout("the tx queue to leave full");
            end
            if (status[ST_TX_FULL]) begin
                full_seen++;
                // a full queue is also past the almost full mark
                check("STATUS tx almost full", status[ST_TX_ALMOST_FULL], 32'd1);
            end else begin
                value = random_byte();
                tx_model.push_back(value);
                wb_write(ADDR_DATA, wb_data_t'(value));
                sent++;
            end
        end
    endtask

    task automatic wait_rx_ready();
        wb_data_t status;
        int       polls;
        polls = 0;
        do begin
            wb_read(ADDR_STATUS, status);
            polls++;
        end while (status[ST_RX_EMPTY] && polls < POLL_LIMIT);
        if (status[ST_RX_EMPTY]) begin
            abort_on_timeout("a byte in the rx queue");
        end
    endtask

    initial begin
        wb_data_t rdata;
        byte_t    value;
        int       full_seen;
        int       i;
        rst_n_i     = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = 4'h0;
        rx_i        = 1'b1;
        lfsr_state  = 32'he4f9;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // idle state after reset
        check("tx_o", tx_o, 32'd1);
        wb_read(ADDR_STATUS, rdata);
        check("STATUS", rdata, expected_status(1, 0, 0, 1, 0, 0, 0, 0));
        wb_read(ADDR_DATA, rdata);
        check("DATA empty read", rdata, 32'd0);

        fork
            write_random_bytes(20);
            expect_tx_bytes(20);
        join

        for (i = 0; i < 20; i++) begin
            value = random_byte();
            rx_model.push_back(value);
            send_frame(value, 1'b0);
            wait_rx_ready();
            wb_read(ADDR_DATA, rdata);
            check("DATA rx byte", rdata, wb_data_t'(rx_model.pop_front()));
        end

        // overflow the rx queue, last four frames are lost
        for (i = 0; i < 35; i++) begin
            value = random_byte();
            if (i < QUEUE_DEPTH) begin
                rx_model.push_back(value);
            end
            send_frame(value, 1'b0);
        end
        wb_read(ADDR_STATUS, rdata);
        check("STATUS overrun", rdata, expected_status(1, 0, 0, 0, 1, 1, 1, 0));
        wb_read(ADDR_STATUS, rdata);
        check("STATUS overrun cleared", rdata, expected_status(1, 0, 0, 0, 1, 1, 0, 0));
        for (i = 0; i < QUEUE_DEPTH; i++) begin
            wb_read(ADDR_DATA, rdata);
            check("DATA drained byte", rdata, wb_data_t'(rx_model.pop_front()));
        end
        wb_read(ADDR_STATUS, rdata);
        check("STATUS drained", rdata, expected_status(1, 0, 0, 1, 0, 0, 0, 0));

        value = random_byte();
        send_frame(value, 1'b1);
        wb_read(ADDR_STATUS, rdata);
        check("STATUS frame error", rdata, expected_status(1, 0, 0, 1, 0, 0, 0, 1));
        wb_read(ADDR_STATUS, rdata);
        check("STATUS frame error cleared", rdata, expected_status(1, 0, 0, 1, 0, 0, 0, 0));

        fork
            write_when_not_full(40, full_seen);
            expect_tx_bytes(40);
        join
        check("STATUS reads with tx full", (full_seen > 0) ? 32'd1 : 32'd0, 32'd1);
        check("tx_model left over", tx_model.size(), 32'd0);

        $display("Regression passed");
        $finish;
    end

endmodule

// File: wb_uart.f
common/uart_pkg.sv
common/fifo_if.sv
hdl/fifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/wb_uart_regs.sv
hdl/wb_uart.sv
sim/tb_wb_uart.sv

// File: Makefile
TOP := tb_wb_uart

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): wb_uart.f $(shell cat wb_uart.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f wb_uart.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Regression passed" sim.log || { echo "no pass line in sim.log"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --top-module wb_uart -f wb_uart.f

clean:
	rm -rf obj_dir sim.log
